// ==== Makefile ====
# Verilator build and run of the cycle bridge testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = cycleBridgeTb
FILELIST  = cycleBridge.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "Simulation gave no result, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== cycleBridge.f ====
rtl/cycleBridgePkg.sv
rtl/cpuBusFront.sv
rtl/cycleSequencer.sv
rtl/laneSteering.sv
rtl/cycleBridge.sv
verif/cycleBridgeTb.sv

// ==== rtl/cpuBusFront.sv ====
// CPU bus front end that qualifies each transfer start and hands a sized request to the sequencer
`timescale 1ns/1ps

module cpuBusFront (
    input  logic                   CLK80,
    input  logic                   RESETn,
    input  logic                   TS_CPUn,
    input  logic                   RnW,
    input  cycleBridgePkg::sizeT   SIZ,
    input  logic [1:0]             A_040,
    input  logic                   PORTSIZE,
    input  logic                   BGn,
    input  logic                   LBENn,
    output cycleBridgePkg::cpuReqT req,
    output logic                   reqValid,
    output logic                   split
);

    ////////////////////
    // Transfer start
    ////////////////////

    // A cycle goes out to the local bus only when the CPU owns the bus
    // and the address does not decode to on-board memory
    // LBENn low means the on-board SDRAM answers the cycle itself
    logic forward;

    // Long and line sizes both move 32 bits in one CPU cycle
    logic longSize;

    assign forward = !TS_CPUn && !BGn && LBENn;
    assign longSize = cycleBridgePkg::sizeIsLong(SIZ);

    // Control flags
    // ReqValid is a single cycle pulse that follows the CPU TS pulse by one clock
    // Split marks a long word that has to be cut into two word cycles
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            reqValid <= 1'b0;
            split <= 1'b0;
        end else begin
            reqValid <= forward;
            if (forward) begin
                // A word port cannot take 32 bits at once
                split <= longSize && PORTSIZE;
            end
        end
    end

    ////////////////////
    // Request capture
    ////////////////////

    // The request fields stay stable until the next forwarded start
    // The CPU keeps only one cycle open, so the sequencer may read them
    // at any point of the running cycle
    always_ff @(posedge CLK80) begin
        if (forward) begin
            req.addrLow <= A_040;
            req.siz <= SIZ;
            req.rnw <= RnW;
            req.portWord <= PORTSIZE;
        end
    end

    // TS from the CPU lasts one clock, so two starts never touch
    reqPulseSingle: assert property (
        @(posedge CLK80) disable iff (!RESETn)
        reqValid |=> !reqValid
    ) else $error("reqValid held high for two cycles");

endmodule

// ==== rtl/cycleBridge.sv ====
// Top level of the 68040 to local expansion bus cycle bridge, wiring front end, sequencer and data path
`timescale 1ns/1ps

module cycleBridge #(
    parameter int dataW = cycleBridgePkg::DATA_W
) (
    input  logic                 CLK80,
    input  logic                 RESETn,

    // CPU bus
    input  logic                 TS_CPUn,
    input  logic                 RnW,
    input  cycleBridgePkg::sizeT SIZ,
    input  logic [1:0]           A_040,
    input  logic                 BGn,
    input  logic                 LBENn,
    input  logic                 PORTSIZE,
    input  logic [dataW-1:0]     dataCpuIn,
    output logic [dataW-1:0]     dataCpuOut,
    output logic                 TAn,
    output logic                 TBI_CPUn,

    // Local expansion bus
    output logic                 TSn,
    input  logic                 TACKn,
    output logic [1:0]           A_LOCAL,
    input  logic [dataW-1:0]     dataLocalIn,
    output logic [dataW-1:0]     dataLocalOut
);

    cycleBridgePkg::cpuReqT     req;
    cycleBridgePkg::localCycleT cyc;
    logic reqValid;
    logic split;
    logic holdUpper;

    ////////////////////
    // Transfer start
    ////////////////////

    cpuBusFront front (
        .CLK80(CLK80), .RESETn(RESETn), .TS_CPUn(TS_CPUn), .RnW(RnW), .SIZ(SIZ),
        .A_040(A_040), .PORTSIZE(PORTSIZE), .BGn(BGn), .LBENn(LBENn),
        .req(req), .reqValid(reqValid), .split(split)
    );

    ////////////////////
    // Cycle sequencing
    ////////////////////

    cycleSequencer sequencer (
        .CLK80(CLK80), .RESETn(RESETn), .req(req), .reqValid(reqValid), .split(split),
        .TACKn(TACKn), .TSn(TSn), .TAn(TAn), .TBI_CPUn(TBI_CPUn),
        .cyc(cyc), .holdUpper(holdUpper)
    );

    // Local address follows the sequencer so both halves of a split are placed
    assign A_LOCAL = cyc.addrLow;

    ////////////////////
    // Data pass through
    ////////////////////

    laneSteering #(
        .dataW(dataW)
    ) lanes (
        .CLK80(CLK80), .RESETn(RESETn), .cyc(cyc), .rnw(req.rnw), .holdUpper(holdUpper),
        .TACKn(TACKn), .dataCpuIn(dataCpuIn), .dataCpuOut(dataCpuOut),
        .dataLocalIn(dataLocalIn), .dataLocalOut(dataLocalOut)
    );

endmodule

// ==== rtl/cycleBridgePkg.sv ====
// Shared types and constants for the CPU to local bus cycle bridge, referenced by scoped name
package cycleBridgePkg;

    // Width of both data buses, fixed by the local expansion bus
    localparam int DATA_W = 32;

    // Transfer size as driven on the CPU SIZ pins
    typedef logic [1:0] sizeT;

    localparam sizeT sizeLong = 2'b00;
    localparam sizeT sizeByte = 2'b01;
    localparam sizeT sizeWord = 2'b10;
    localparam sizeT sizeLine = 2'b11;

    // Local address bits for the two halves of a split long word
    localparam logic [1:0] firstWordAddr = 2'b00;
    localparam logic [1:0] secondWordAddr = 2'b10;

    // Request captured at a forwarded CPU transfer start
    typedef struct packed {
        logic [1:0] addrLow;
        sizeT       siz;
        // High for a read from the local bus
        logic       rnw;
        // High when the addressed local port is only 16 bits wide
        logic       portWord;
    } cpuReqT;

    // State of the local cycle as seen by the data path
    typedef struct packed {
        // A local cycle is running
        logic       active;
        // Set while the lower half of a split long word is moved
        logic       secondWord;
        // Address bits driven onto A_LOCAL
        logic [1:0] addrLow;
    } localCycleT;

    // Sequencer phases
    // Single covers a byte, word or long access that needs one local cycle
    // A split walks firstWord, gap and secondWord
    typedef enum logic [2:0] {
        idle       = 3'd0,
        single     = 3'd1,
        firstWord  = 3'd2,
        gap        = 3'd3,
        secondWord = 3'd4
    } phaseT;

    // Line transfers reach the local bus as plain long words
    function automatic logic sizeIsLong(input sizeT siz);
        return (siz == sizeLong) || (siz == sizeLine);
    endfunction

endpackage

// ==== rtl/cycleSequencer.sv ====
// Local cycle state machine that turns each CPU request into one or two local bus cycles
`timescale 1ns/1ps

module cycleSequencer (
    input  logic                       CLK80,
    input  logic                       RESETn,
    input  cycleBridgePkg::cpuReqT     req,
    input  logic                       reqValid,
    input  logic                       split,
    input  logic                       TACKn,
    output logic                       TSn,
    output logic                       TAn,
    output logic                       TBI_CPUn,
    output cycleBridgePkg::localCycleT cyc,
    output logic                       holdUpper
);

    cycleBridgePkg::phaseT phase;

    // Set in the cycle whose acknowledge ends the whole CPU transfer
    logic lastAck;

    ////////////////////
    // Cycle end
    ////////////////////

    // The first acknowledge of a split only closes the upper half
    // It latches the upper word and never reaches the CPU
    assign holdUpper = (phase == cycleBridgePkg::firstWord) && !TACKn;

    // Gap is the start cycle of the second half
    // A fast responder may already answer in it
    assign lastAck = !TACKn && ((phase == cycleBridgePkg::single) ||
                                (phase == cycleBridgePkg::gap) ||
                                (phase == cycleBridgePkg::secondWord));

    ////////////////////
    // State machine
    ////////////////////

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            phase <= cycleBridgePkg::idle;
            TSn <= 1'b1;
            TAn <= 1'b1;
            TBI_CPUn <= 1'b1;
            cyc <= '0;
        end else begin
            // Strobes are one clock wide unless a branch below asserts them
            TSn <= 1'b1;
            TAn <= 1'b1;
            TBI_CPUn <= 1'b1;

            case (phase)
                cycleBridgePkg::idle: begin
                    // Acknowledges that show up here belong to nobody
                    if (reqValid) begin
                        TSn <= 1'b0;
                        cyc.active <= 1'b1;
                        cyc.secondWord <= 1'b0;
                        if (split) begin
                            // Upper word first, placed at offset 0 of the word port
                            cyc.addrLow <= cycleBridgePkg::firstWordAddr;
                            phase <= cycleBridgePkg::firstWord;
                        end else begin
                            cyc.addrLow <= req.addrLow;
                            phase <= cycleBridgePkg::single;
                        end
                    end
                end

                cycleBridgePkg::firstWord: begin
                    // Start the lower half right behind the first acknowledge
                    if (!TACKn) begin
                        TSn <= 1'b0;
                        cyc.secondWord <= 1'b1;
                        cyc.addrLow <= cycleBridgePkg::secondWordAddr;
                        phase <= cycleBridgePkg::gap;
                    end
                end

                cycleBridgePkg::gap: begin
                    if (TACKn) begin
                        phase <= cycleBridgePkg::secondWord;
                    end
                end

                cycleBridgePkg::single,
                cycleBridgePkg::secondWord: begin
                    // Wait here for as long as the responder needs
                end

                default: begin
                    phase <= cycleBridgePkg::idle;
                end
            endcase

            // One TA per CPU cycle, with burst inhibit on word ports
            if (lastAck) begin
                TAn <= 1'b0;
                TBI_CPUn <= !req.portWord;
                cyc.active <= 1'b0;
                cyc.secondWord <= 1'b0;
                phase <= cycleBridgePkg::idle;
            end
        end
    end

    // A new start never overlaps the end of the previous CPU cycle
    tsTaApart: assert property (
        @(posedge CLK80) disable iff (!RESETn)
        !(!TSn && !TAn)
    ) else $error("TSn and TAn low in the same cycle");

    // Stray acknowledges in idle must not end a CPU cycle
    idleAckIgnored: assert property (
        @(posedge CLK80) disable iff (!RESETn)
        (phase == cycleBridgePkg::idle) && !TACKn |=> TAn
    ) else $error("TACKn in idle produced a TAn");

endmodule

// ==== rtl/laneSteering.sv ====
// Byte lane steering between CPU and local data buses, with the upper word hold for split reads
`timescale 1ns/1ps

module laneSteering #(
    parameter int dataW = cycleBridgePkg::DATA_W
) (
    input  logic                       CLK80,
    input  logic                       RESETn,
    input  cycleBridgePkg::localCycleT cyc,
    input  logic                       rnw,
    input  logic                       holdUpper,
    input  logic                       TACKn,
    input  logic [dataW-1:0]           dataCpuIn,
    output logic [dataW-1:0]           dataCpuOut,
    input  logic [dataW-1:0]           dataLocalIn,
    output logic [dataW-1:0]           dataLocalOut
);

    localparam int halfW = dataW / 2;

    // Word ports sit on the upper two lanes at offset 0
    // A word at offset 2 lives on the lower CPU lanes and must be moved up
    logic flip;
    logic [dataW-1:0] readSteered;
    logic [dataW-1:0] writeSteered;

    // Upper word of a split read, kept until the second half ends
    logic [halfW-1:0] upperHeld;
    logic upperValid;

    // Any acknowledge that is not the first half of a split closes the CPU cycle
    logic finalAck;

    assign flip = cyc.active && (cyc.addrLow[1] || cyc.secondWord);
    assign finalAck = cyc.active && !TACKn && !holdUpper;

    ////////////////////
    // Lane flip
    ////////////////////

    // Reads copy the upper local lanes onto the lower CPU lanes
    assign readSteered = flip ? {dataLocalIn[dataW-1:halfW], dataLocalIn[dataW-1:halfW]}
                              : dataLocalIn;

    // Writes copy the lower CPU lanes up, the lower local lanes always pass through
    assign writeSteered = flip ? {dataCpuIn[halfW-1:0], dataCpuIn[halfW-1:0]} : dataCpuIn;

    // Bridge keeps its write lanes quiet during reads
    assign dataLocalOut = rnw ? '0 : writeSteered;

    ////////////////////
    // Read hold
    ////////////////////

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            upperValid <= 1'b0;
        end else if (holdUpper) begin
            upperValid <= 1'b1;
        end else if (finalAck) begin
            upperValid <= 1'b0;
        end
    end

    // Read data is registered with TA so the CPU samples a stable word
    always_ff @(posedge CLK80) begin
        if (holdUpper) begin
            upperHeld <= dataLocalIn[dataW-1:halfW];
        end
        if (finalAck && rnw) begin
            dataCpuOut <= upperValid ? {upperHeld, readSteered[halfW-1:0]} : readSteered;
        end
    end

    // The second half of a split always finds the upper word in place
    upperBeforeLower: assert property (
        @(posedge CLK80) disable iff (!RESETn)
        cyc.active && cyc.secondWord && !TACKn |-> upperValid
    ) else $error("second word acknowledged without a held upper word");

endmodule

// ==== verif/cycleBridgePatterns.txt ====
// rnw siz addr portWord onBoard busGranted cpuWrite localRead1 localRead2 (stimulus, hex)
// then expected localAddr1 localAddr2 localWrite1 localWrite2 cpuRead (hex, unused ones are 0)
1 0 0 0 0 1 00000000 11223344 00000000 0 0 00000000 00000000 11223344
0 0 0 0 0 1 CAFEF00D 00000000 00000000 0 0 CAFEF00D 00000000 00000000
1 2 2 1 0 1 00000000 A1B2C3D4 00000000 2 0 00000000 00000000 A1B2A1B2
0 2 2 1 0 1 1234ABCD 00000000 00000000 2 0 ABCDABCD 00000000 00000000
1 0 0 1 0 1 00000000 DEAD0001 BEEF0002 0 2 00000000 00000000 DEADBEEF
0 0 0 1 0 1 87654321 00000000 00000000 0 2 87654321 43214321 00000000
1 0 0 0 1 1 00000000 5555AAAA 00000000 0 0 00000000 00000000 00000000
0 2 2 1 0 0 FFFF0000 00000000 00000000 0 0 00000000 00000000 00000000
1 2 0 1 0 1 00000000 7E7E1111 00000000 0 0 00000000 00000000 7E7E1111
1 3 0 1 0 1 00000000 01020304 05060708 0 2 00000000 00000000 01020506
1 1 3 0 0 1 00000000 0A0B0C0D 00000000 3 0 00000000 00000000 0A0B0A0B
0 1 1 0 0 1 00EE0000 00000000 00000000 1 0 00EE0000 00000000 00000000
1 0 0 1 1 1 00000000 12345678 9ABCDEF0 0 0 00000000 00000000 00000000
0 0 0 1 0 0 0BADF00D 00000000 00000000 0 0 00000000 00000000 00000000
0 3 0 1 0 1 13579BDF 00000000 00000000 0 2 13579BDF 9BDF9BDF 00000000
1 3 0 0 0 1 00000000 FEDCBA98 00000000 0 0 00000000 00000000 FEDCBA98
1 0 0 1 0 1 00000000 0000FFFF FFFF0000 0 2 00000000 00000000 0000FFFF
0 2 0 1 0 1 2468ACE0 00000000 00000000 0 0 2468ACE0 00000000 00000000
0 1 3 1 0 1 000000C3 00000000 00000000 3 0 00C300C3 00000000 00000000
1 0 0 0 0 1 00000000 600DD00D 00000000 0 0 00000000 00000000 600DD00D

// ==== verif/cycleBridgeTb.sv ====
// Testbench for the cycle bridge that replays CPU transfers from a pattern file against a local bus model
`timescale 1ns/1ps

module cycleBridgeTb;

    localparam int dataW = cycleBridgePkg::DATA_W;
    localparam int fieldCount = 14;
    localparam int maxPatterns = 32;

    logic CLK80 = 1'b0;
    logic RESETn;
    logic TS_CPUn;
    logic RnW;
    cycleBridgePkg::sizeT SIZ;
    logic [1:0] A_040;
    logic BGn;
    logic LBENn;
    logic PORTSIZE;
    logic [dataW-1:0] dataCpuIn;
    logic [dataW-1:0] dataCpuOut;
    logic TAn;
    logic TBI_CPUn;
    logic TSn;
    logic TACKn;
    logic [1:0] A_LOCAL;
    logic [dataW-1:0] dataLocalIn;
    logic [dataW-1:0] dataLocalOut;

    // Pattern words, fourteen per CPU transfer
    logic [31:0] patterns [0:maxPatterns*fieldCount-1];
    int patternsLoaded = 0;

    // Words the responder returns for the running pattern, in local cycle order
    logic [31:0] readWord [0:1];

    // What the responder saw on the local bus for each local cycle
    logic [1:0] seenAddr [0:1];
    logic [31:0] seenWrite [0:1];
    int localCount = 0;
    int cycleBase = 0;

    // Strobe counters, sampled mid cycle
    int tsCount = 0;
    int taCount = 0;

    int valueErrors = 0;
    int otherErrors = 0;
    integer seed = 6;

    cycleBridge #(
        .dataW(dataW)
    ) dut (
        .CLK80(CLK80), .RESETn(RESETn), .TS_CPUn(TS_CPUn), .RnW(RnW), .SIZ(SIZ),
        .A_040(A_040), .BGn(BGn), .LBENn(LBENn), .PORTSIZE(PORTSIZE),
        .dataCpuIn(dataCpuIn), .dataCpuOut(dataCpuOut), .TAn(TAn), .TBI_CPUn(TBI_CPUn),
        .TSn(TSn), .TACKn(TACKn), .A_LOCAL(A_LOCAL),
        .dataLocalIn(dataLocalIn), .dataLocalOut(dataLocalOut)
    );

    // 40 ns period
    always #20 CLK80 = ~CLK80;

    ////////////////////
    // Checks
    ////////////////////

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("** Error at %0d ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("** Error at %0d ns: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic printCounts();
        $display("Result: %0d value errors, %0d other errors", valueErrors, otherErrors);
    endtask

    // Counts every TSn and TAn pulse in the middle of the cycle, where both are settled
    always @(negedge CLK80) begin
        if (RESETn) begin
            if (!TSn) begin
                tsCount++;
            end
            if (!TAn) begin
                taCount++;
            end else begin
                // Burst inhibit only ever goes low together with TA
                checkBit("TBI_CPUn", TBI_CPUn, 1'b1);
            end
        end
    end

    ////////////////////
    // Local responder
    ////////////////////

    // Records one local cycle, waits 0 to 3 clocks and answers with a one clock TACKn
    task automatic answerLocalCycle();
        int slot;
        int waitCycles;
        slot = localCount - cycleBase;
        waitCycles = $unsigned($random(seed)) % 4;
        if (slot < 2) begin
            seenAddr[slot] = A_LOCAL;
            seenWrite[slot] = dataLocalOut;
        end
        localCount++;
        repeat (waitCycles) @(posedge CLK80);
        @(posedge CLK80);
        #2;
        TACKn = 1'b0;
        dataLocalIn = (slot < 2) ? readWord[slot] : '0;
        @(posedge CLK80);
        #2;
        TACKn = 1'b1;
        dataLocalIn = '0;
    endtask

    initial begin
        TACKn = 1'b1;
        dataLocalIn = '0;
        forever begin
            @(negedge CLK80);
            if (RESETn && !TSn) begin
                answerLocalCycle();
            end
        end
    end

    ////////////////////
    // CPU side
    ////////////////////

    // One CPU transfer from the pattern table, followed by its checks
    task automatic runPattern(input int p);
        int base;
        int tsStart;
        int taStart;
        int expCycles;
        logic portWord;
        logic longSize;
        logic forwarded;
        base = p * fieldCount;
        portWord = patterns[base + 3][0];
        // Line transfers count as long words
        longSize = (patterns[base + 1][1:0] == 2'b00) || (patterns[base + 1][1:0] == 2'b11);
        // On-board memory and a bus held by another master both keep the local bus quiet
        forwarded = !patterns[base + 4][0] && patterns[base + 5][0];
        if (!forwarded) begin
            expCycles = 0;
        end else if (longSize && portWord) begin
            expCycles = 2;
        end else begin
            expCycles = 1;
        end
        readWord[0] = patterns[base + 7];
        readWord[1] = patterns[base + 8];
        cycleBase = localCount;
        tsStart = tsCount;
        taStart = taCount;

        @(posedge CLK80);
        #2;
        TS_CPUn = 1'b0;
        RnW = patterns[base][0];
        SIZ = patterns[base + 1][1:0];
        A_040 = patterns[base + 2][1:0];
        PORTSIZE = portWord;
        LBENn = !patterns[base + 4][0];
        BGn = !patterns[base + 5][0];
        dataCpuIn = patterns[base + 6];
        @(posedge CLK80);
        #2;
        TS_CPUn = 1'b1;

        if (forwarded) begin
            // The watchdog bounds this wait
            @(negedge CLK80);
            while (TAn) begin
                @(negedge CLK80);
            end
            #1;
            checkBit("TBI_CPUn", TBI_CPUn, !portWord);
            if (patterns[base][0]) begin
                checkWord("dataCpuOut", dataCpuOut, patterns[base + 13]);
            end
            // All local starts come before the TA that ends the CPU cycle
            checkWord("TSn pulses before TAn", tsCount - tsStart, expCycles);
            @(negedge CLK80);
            #1;
        end else begin
            // Nothing may move on the local bus during this window
            repeat (8) @(negedge CLK80);
            #1;
        end

        checkWord("TAn pulses", taCount - taStart, forwarded ? 1 : 0);
        checkWord("TSn pulses", tsCount - tsStart, expCycles);
        checkWord("local cycles", localCount - cycleBase, expCycles);
        if (expCycles > 0) begin
            checkWord("A_LOCAL cycle 1", 32'(seenAddr[0]), patterns[base + 9]);
            checkWord("dataLocalOut cycle 1", seenWrite[0], patterns[base + 11]);
        end
        if (expCycles > 1) begin
            checkWord("A_LOCAL cycle 2", 32'(seenAddr[1]), patterns[base + 10]);
            checkWord("dataLocalOut cycle 2", seenWrite[1], patterns[base + 12]);
        end
    endtask

    initial begin
        RESETn = 1'b0;
        TS_CPUn = 1'b1;
        RnW = 1'b1;
        SIZ = cycleBridgePkg::sizeLong;
        A_040 = 2'b00;
        BGn = 1'b0;
        LBENn = 1'b1;
        PORTSIZE = 1'b0;
        dataCpuIn = '0;

        // Unused entries get a value above 1 so the end of the table shows in the rnw column
        for (int i = 0; i < maxPatterns * fieldCount; i++) begin
            patterns[i] = 32'hF000_0000 | 32'(i);
        end
        $readmemh("verif/cycleBridgePatterns.txt", patterns);
        while (patternsLoaded < maxPatterns && patterns[patternsLoaded * fieldCount] <= 32'd1) begin
            patternsLoaded++;
        end
        assert (patternsLoaded > 0) else begin
            otherErrors++;
            $display("The pattern file verif/cycleBridgePatterns.txt gave no usable transfers");
        end

        repeat (2) @(posedge CLK80);
        #2;
        RESETn = 1'b1;

        // All strobes idle right after reset
        @(negedge CLK80);
        checkBit("TSn", TSn, 1'b1);
        checkBit("TAn", TAn, 1'b1);
        checkBit("TBI_CPUn", TBI_CPUn, 1'b1);

        for (int p = 0; p < patternsLoaded; p++) begin
            runPattern(p);
        end

        printCounts();
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Worst case is about 12 clocks per transfer plus reset
    initial begin
        int limit;
        #1;
        limit = patternsLoaded * 12 + 20;
        repeat (limit) @(posedge CLK80);
        otherErrors++;
        $display("Timeout: the transfers did not finish within %0d clock cycles", limit);
        printCounts();
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
